/* cache_subsys.f */
rtl/cache_pkg.sv
rtl/cache_data_array.sv
rtl/cache_tag_array.sv
rtl/main_memory.sv
rtl/cache_fill_fsm.sv
rtl/cache_top.sv
verification/cache_tb.sv

/* Bender.yml */
package:
  name: cache_subsys

sources:
  # rtl, package first
  - rtl/cache_pkg.sv
  - rtl/cache_data_array.sv
  - rtl/cache_tag_array.sv
  - rtl/main_memory.sv
  - rtl/cache_fill_fsm.sv
  - rtl/cache_top.sv

  # testbench
  - target: test
    files:
      - verification/cache_tb.sv

/* verification/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

	import cache_pkg::*;

	logic                  clk;
	logic                  rst;
	logic                  cpu_rd;
	logic                  cpu_wr;
	cache_addr_t           cpu_addr;
	logic [word_width-1:0] cpu_wdata;
	logic [word_width-1:0] cpu_rdata;
	logic                  cpu_rvalid;
	logic                  cpu_stall;

	// expectations for the request in progress
	string                 test_name;
	logic [word_width-1:0] exp_rdata;
	logic                  want_miss;
	logic                  want_hit;
	logic                  first_cycle; // high only in the first cycle of a read

	logic [word_width-1:0] sb [bit [mem_addr_width-1:0]]; // words written so far
	integer                seed;

	cache_top UUT (
		.clk        (clk),
		.rst        (rst),
		.cpu_rd     (cpu_rd),
		.cpu_wr     (cpu_wr),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_rdata  (cpu_rdata),
		.cpu_rvalid (cpu_rvalid),
		.cpu_stall  (cpu_stall)
	);

	always #10 clk = ~clk;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	function automatic logic [word_width-1:0] make_addr(input logic [tag_width-1:0] tag,
		input logic [index_width-1:0] index, input logic [offset_width-1:0] offset);
		return {tag, index, offset};
	endfunction

	// holds the read until cpu_rvalid
	// kind 1 expects a miss and kind 2 a hit
	task automatic read_word(input string name, input logic [word_width-1:0] addr,
		input int kind);
		int waited;
		test_name = name;
		exp_rdata = sb[addr[mem_addr_width-1:0]];
		want_miss = (kind == 1);
		want_hit = (kind == 2);
		first_cycle = 1'b1;
		cpu_addr.raw = addr;
		cpu_rd = 1'b1;
		waited = 0;
		@(negedge clk);
		while (!cpu_rvalid) begin
			if (waited == 100) begin
				report_failure($sformatf("%s: cpu_rvalid did not rise within 100 cycles",
					name));
			end
			@(posedge clk);
			#2;
			first_cycle = 1'b0;
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		#2;
		cpu_rd = 1'b0;
		first_cycle = 1'b0;
		want_miss = 1'b0;
		want_hit = 1'b0;
	endtask

	// write through takes exactly one edge
	task automatic write_word(input string name, input logic [word_width-1:0] addr,
		input logic [word_width-1:0] data);
		test_name = name;
		cpu_addr.raw = addr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		@(posedge clk);
		#2;
		cpu_wr = 1'b0;
		sb[addr[mem_addr_width-1:0]] = data;
	endtask

	a_read_data: assert property (
		@(posedge clk) disable iff (rst)
		cpu_rvalid |-> cpu_rdata == exp_rdata
	) else report_failure($sformatf("ERR %s read data expected %h actual %h",
		test_name, $sampled(exp_rdata), $sampled(cpu_rdata)));

	a_miss_stalls: assert property (
		@(posedge clk) disable iff (rst)
		first_cycle && want_miss |-> cpu_stall && !cpu_rvalid
	) else report_failure($sformatf("ERR %s miss stall expected 1 actual %0b",
		test_name, $sampled(cpu_stall)));

	a_hit_same_cycle: assert property (
		@(posedge clk) disable iff (rst)
		first_cycle && want_hit |-> cpu_rvalid && !cpu_stall
	) else report_failure($sformatf("ERR %s hit rvalid expected 1 actual %0b",
		test_name, $sampled(cpu_rvalid)));

	a_write_no_stall: assert property (
		@(posedge clk) disable iff (rst)
		cpu_wr |-> !cpu_stall
	) else report_failure($sformatf("ERR %s write stall expected 0 actual %0b",
		test_name, $sampled(cpu_stall)));

	// covers the quiet period after reset as well
	a_idle_quiet: assert property (
		@(posedge clk) disable iff (rst)
		!cpu_rd |-> !cpu_stall && !cpu_rvalid
	) else report_failure($sformatf("ERR %s idle stall/rvalid expected 00 actual %0b%0b",
		test_name, $sampled(cpu_stall), $sampled(cpu_rvalid)));

	initial begin
		logic [tag_width-1:0]   tag_a;
		logic [tag_width-1:0]   tag_b;
		logic [index_width-1:0] index_ab;
		logic [tag_width-1:0]   rnd_tags [3];
		logic [index_width-1:0] rnd_index [4];
		logic [word_width-1:0]  addr;
		logic [31:0]            rnd;
		logic [31:0]            rnd_data;

		clk = 1'b0;
		rst = 1'b1;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		test_name = "reset";
		exp_rdata = '0;
		want_miss = 1'b0;
		want_hit = 1'b0;
		first_cycle = 1'b0;
		seed = 32'h813a;

		tag_a = 8'h44;
		tag_b = 8'h9b; // same index as tag_a with another tag
		index_ab = 5'd5;
		rnd_tags = '{8'h21, 8'h52, 8'hc3};
		rnd_index = '{5'd5, 5'd12, 5'd19, 5'd27};

		repeat (3) @(posedge clk);
		#2;
		rst = 1'b0;
		test_name = "after_reset";
		repeat (4) @(posedge clk); // quiet cycles checked by a_idle_quiet
		#2;

		// cold miss on a block that only memory holds
		for (int i = 0; i < block_words; i++) begin
			rnd_data = $random(seed);
			write_word("fill_block_a", make_addr(tag_a, index_ab, i[offset_width-1:0]),
				rnd_data[word_width-1:0]);
		end
		read_word("cold_miss", make_addr(tag_a, index_ab, 3'd3), 1);

		// the whole block is now cached
		for (int i = 0; i < block_words; i++) begin
			read_word("read_hit", make_addr(tag_a, index_ab, i[offset_width-1:0]), 2);
		end

		write_word("write_hit", make_addr(tag_a, index_ab, 3'd6), 16'h5a3c);
		read_word("write_hit_read", make_addr(tag_a, index_ab, 3'd6), 2);

		// second block on the same line goes to memory only
		for (int i = 0; i < block_words; i++) begin
			rnd_data = $random(seed);
			write_word("fill_block_b", make_addr(tag_b, index_ab, i[offset_width-1:0]),
				rnd_data[word_width-1:0]);
		end
		read_word("evict_read_b", make_addr(tag_b, index_ab, 3'd2), 1);
		read_word("evict_read_a", make_addr(tag_a, index_ab, 3'd6), 1);
		read_word("evict_read_b2", make_addr(tag_b, index_ab, 3'd7), 1);
		read_word("evict_read_a2", make_addr(tag_a, index_ab, 3'd6), 1);
		read_word("evict_hit_a", make_addr(tag_a, index_ab, 3'd0), 2);

		// random traffic reads only words the scoreboard knows
		for (int n = 0; n < 300; n++) begin
			rnd = $random(seed);
			addr = make_addr(rnd_tags[$unsigned(rnd[15:0]) % 3], rnd_index[rnd[17:16]],
				rnd[20:18]);
			rnd_data = $random(seed);
			if (rnd[24] && sb.exists(addr[mem_addr_width-1:0])) begin
				read_word("random_read", addr, 0);
			end else begin
				write_word("random_write", addr, rnd_data[word_width-1:0]);
			end
		end

		test_name = "end";
		repeat (3) @(posedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_top (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             cpu_rd,
	input  wire logic                             cpu_wr,
	input  wire cache_pkg::cache_addr_t           cpu_addr,
	input  wire logic [cache_pkg::word_width-1:0] cpu_wdata,
	output logic [cache_pkg::word_width-1:0]      cpu_rdata,
	output logic                                  cpu_rvalid,
	output logic                                  cpu_stall
);

	import cache_pkg::*;

	logic                    hit;
	logic                    busy;
	logic                    mem_req_valid;
	cache_addr_t             mem_req_addr; // also names the line being filled
	logic                    mem_rsp_valid;
	logic [word_width-1:0]   mem_rsp_data;
	logic                    mem_wr;
	logic                    fill_wr;
	logic [offset_width-1:0] fill_offset;
	logic [word_width-1:0]   fill_data;
	logic                    tag_wr;
	logic                    array_wr;
	logic [index_width-1:0]  array_index;
	logic [offset_width-1:0] array_offset;
	logic [word_width-1:0]   array_data;

	assign cpu_rvalid = cpu_rd & hit & ~busy;
	assign mem_wr     = cpu_wr & ~busy; // write through, never during a fill

	// fill words own the write port while busy, write hits otherwise
	assign array_wr     = busy ? fill_wr : (cpu_wr & hit);
	assign array_index  = busy ? mem_req_addr.fields.index : cpu_addr.fields.index;
	assign array_offset = busy ? fill_offset : cpu_addr.fields.offset;
	assign array_data   = busy ? fill_data : cpu_wdata;

	cache_fill_fsm u_fill (
		.clk           (clk),
		.rst           (rst),
		.cpu_rd        (cpu_rd),
		.hit           (hit),
		.cpu_addr      (cpu_addr),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_data  (mem_rsp_data),
		.busy          (busy),
		.stall         (cpu_stall),
		.mem_req_valid (mem_req_valid),
		.mem_req_addr  (mem_req_addr),
		.fill_wr       (fill_wr),
		.fill_offset   (fill_offset),
		.fill_data     (fill_data),
		.tag_wr        (tag_wr)
	);

	cache_tag_array u_tags (
		.clk         (clk),
		.rst         (rst),
		.lookup_addr (cpu_addr),
		.tag_wr      (tag_wr),
		.fill_addr   (mem_req_addr),
		.hit         (hit)
	);

	cache_data_array u_data (
		.clk       (clk),
		.rd_index  (cpu_addr.fields.index),
		.rd_offset (cpu_addr.fields.offset),
		.wr_en     (array_wr),
		.wr_index  (array_index),
		.wr_offset (array_offset),
		.wr_data   (array_data),
		.rd_data   (cpu_rdata)
	);

	main_memory u_mem (
		.clk       (clk),
		.rst       (rst),
		.req_valid (mem_req_valid),
		.req_addr  (mem_req_addr.raw),
		.wr        (mem_wr),
		.wr_addr   (cpu_addr.raw),
		.wdata     (cpu_wdata),
		.rsp_valid (mem_rsp_valid),
		.rsp_data  (mem_rsp_data)
	);

endmodule

`default_nettype wire

/* rtl/cache_fill_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             cpu_rd,
	input  wire logic                             hit,
	input  wire cache_pkg::cache_addr_t           cpu_addr,
	input  wire logic                             mem_rsp_valid,
	input  wire logic [cache_pkg::word_width-1:0] mem_rsp_data,
	output logic                                  busy,
	output logic                                  stall,
	output logic                                  mem_req_valid,
	output cache_pkg::cache_addr_t                mem_req_addr,
	output logic                                  fill_wr,
	output logic [cache_pkg::offset_width-1:0]    fill_offset,
	output logic [cache_pkg::word_width-1:0]      fill_data,
	output logic                                  tag_wr
);

	import cache_pkg::*;

	logic                    miss;
	cache_addr_t             base; // block address of the miss with offset zeroed
	logic [offset_width:0]   req_count; // msb set once all words are requested
	logic [offset_width-1:0] ret_offset; // offset of the next returning word
	logic [offset_width-1:0] ret_next;
	logic                    ret_carry; // last word of the block is returning
	logic [credit_width-1:0] credits;

	assign miss  = cpu_rd & ~hit;
	assign stall = busy | miss; // stall starts in the miss cycle itself

	assign {ret_carry, ret_next} = {1'b0, ret_offset} + 1'b1;

	// request address is the block base plus the request offset
	assign mem_req_addr.raw = base.raw + {{(word_width - offset_width){1'b0}},
		req_count[offset_width-1:0]};
	assign mem_req_valid = busy & ~req_count[offset_width] & (credits != '0);

	assign fill_wr     = busy & mem_rsp_valid;
	assign fill_offset = ret_offset;
	assign fill_data   = mem_rsp_data;
	assign tag_wr      = fill_wr & ret_carry; // tag goes in with the eighth word

	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			req_count  <= '0;
			ret_offset <= '0;
			credits    <= credit_width'(mem_credits);
		end else begin
			if (busy) begin
				busy <= ~tag_wr;
			end else begin
				busy <= miss;
			end

			if (!busy && miss) begin
				req_count <= '0;
			end else if (mem_req_valid) begin
				req_count <= req_count + 1'b1;
			end

			if (fill_wr) begin
				ret_offset <= ret_next; // wraps to zero at the end of the fill
			end

			credits <= credits - credit_width'(mem_req_valid)
				+ credit_width'(mem_rsp_valid);
		end
	end

	// capture on the idle to busy transition
	always_ff @(posedge clk) begin
		if (!busy && miss) begin
			base.fields.tag    <= cpu_addr.fields.tag;
			base.fields.index  <= cpu_addr.fields.index;
			base.fields.offset <= '0;
		end
	end

	a_credit_max: assert property (
		@(posedge clk) disable iff (rst)
		credits <= credit_width'(mem_credits)
	);

	// each accepted request comes back after the fixed memory latency
	a_rsp_latency: assert property (
		@(posedge clk) disable iff (rst)
		mem_req_valid |-> ##mem_latency mem_rsp_valid
	);

	// all words requested and only the eighth still outstanding
	a_tag_with_last_word: assert property (
		@(posedge clk) disable iff (rst)
		tag_wr |-> req_count[offset_width]
			&& credits == credit_width'(mem_credits - 1)
	);

endmodule

`default_nettype wire

/* rtl/main_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module main_memory (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             req_valid,
	input  wire logic [cache_pkg::word_width-1:0] req_addr,
	input  wire logic                             wr,
	input  wire logic [cache_pkg::word_width-1:0] wr_addr,
	input  wire logic [cache_pkg::word_width-1:0] wdata,
	output logic                                  rsp_valid,
	output logic [cache_pkg::word_width-1:0]      rsp_data
);

	import cache_pkg::*;

	logic [word_width-1:0]  mem [mem_words];
	logic [mem_latency-1:0] pipe_valid; // one bit per read in flight
	logic [word_width-1:0]  pipe_data [mem_latency];

	// memory powers up cleared
	initial begin
		for (int i = 0; i < mem_words; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[wr_addr[mem_addr_width-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid <= {pipe_valid[mem_latency-2:0], req_valid};
		end
	end

	// data is read at request time and travels with its valid bit
	always_ff @(posedge clk) begin
		pipe_data[0] <= mem[req_addr[mem_addr_width-1:0]];
		for (int i = 1; i < mem_latency; i++) begin
			pipe_data[i] <= pipe_data[i-1];
		end
	end

	assign rsp_valid = pipe_valid[mem_latency-1];
	assign rsp_data  = pipe_data[mem_latency-1];

	// writes only happen while the cache has no fill running
	a_no_wr_with_rd: assert property (
		@(posedge clk) disable iff (rst)
		!(wr && req_valid)
	);

	// a new read needs a free slot among the credited ones
	a_in_flight_max: assert property (
		@(posedge clk) disable iff (rst)
		$countones(pipe_valid) + req_valid <= mem_credits
	);

endmodule

`default_nettype wire

/* rtl/cache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_tag_array (
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire cache_pkg::cache_addr_t lookup_addr,
	input  wire logic                   tag_wr,
	input  wire cache_pkg::cache_addr_t fill_addr,
	output logic                        hit
);

	import cache_pkg::*;

	logic [tag_width-1:0] tags [num_lines];
	logic [num_lines-1:0] valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (tag_wr) begin
			valid[fill_addr.fields.index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tag_wr) begin
			tags[fill_addr.fields.index] <= fill_addr.fields.tag;
		end
	end

	assign hit = valid[lookup_addr.fields.index]
		&& tags[lookup_addr.fields.index] == lookup_addr.fields.tag;

endmodule

`default_nettype wire

/* rtl/cache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_data_array (
	input  wire logic                               clk,
	input  wire logic [cache_pkg::index_width-1:0]  rd_index,
	input  wire logic [cache_pkg::offset_width-1:0] rd_offset,
	input  wire logic                               wr_en,
	input  wire logic [cache_pkg::index_width-1:0]  wr_index,
	input  wire logic [cache_pkg::offset_width-1:0] wr_offset,
	input  wire logic [cache_pkg::word_width-1:0]   wr_data,
	output logic [cache_pkg::word_width-1:0]        rd_data
);

	import cache_pkg::*;

	// one flat array, line index in the upper address bits
	logic [word_width-1:0] words [num_lines * block_words];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			words[{wr_index, wr_offset}] <= wr_data;
		end
	end

	assign rd_data = words[{rd_index, rd_offset}]; // same cycle read for hits

	a_wr_data_known: assert property (
		@(posedge clk)
		wr_en |-> !$isunknown(wr_data)
	);

endmodule

`default_nettype wire

/* rtl/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// word geometry
	localparam int word_width   = 16;
	localparam int tag_width    = 8;
	localparam int index_width  = 5;
	localparam int offset_width = 3;

	// cache geometry, direct mapped
	localparam int num_lines   = 1 << index_width;
	localparam int block_words = 1 << offset_width;

	// main memory timing and size
	localparam int mem_latency    = 4; // accepted read to response, in cycles
	localparam int mem_credits    = mem_latency; // keeps the read pipe full
	localparam int credit_width   = $clog2(mem_credits + 1);
	localparam int mem_words      = 4096;
	localparam int mem_addr_width = $clog2(mem_words); // higher address bits alias

	// one word address, seen either whole or split into its cache fields
	typedef union packed {
		logic [word_width-1:0] raw;
		struct packed {
			logic [tag_width-1:0]    tag;
			logic [index_width-1:0]  index;
			logic [offset_width-1:0] offset;
		} fields;
	} cache_addr_t;

endpackage

`default_nettype wire
